/* Makefile */
# Verilator build and run of the PS bus testbench

TOOL  = verilator
FLAGS = --binary --assert -j 0
TOP   = tb_ps_bus
FLIST = all.f
BUILD = obj_dir
LOG   = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: sim clean

/* all.f */
source/ps_bus_pkg.sv
source/axi_gp_slave.sv
source/sys_bus_decoder.sv
source/hk_regs.sv
source/gpio_regs.sv
source/ps_bus_top.sv
testbench/ps_bus_asserts.sv
testbench/tb_ps_bus.sv

/* source/axi_gp_slave.sv */
/*
 * AXI3 single-beat slave for the GP port
 * Converts one AXI transaction at a time into system bus strobes
 * Bursts and bus timeouts answer with SLVERR
 */

module axi_gp_slave import ps_bus_pkg::*; #(
  parameter int IW          = 12,  // AXI ID width
  parameter int SYS_TIMEOUT = 16   // Bus timeout in cycles
)(
  input  logic           clk_i       ,
  input  logic           arst_n_i    ,
  // Write address
  input  logic [IW-1:0]  awid_i      ,
  input  logic [32-1:0]  awaddr_i    ,
  input  logic [ 4-1:0]  awlen_i     ,
  input  logic           awvalid_i   ,
  output logic           awready_o   ,
  // Write data
  input  logic [32-1:0]  wdata_i     ,
  input  logic [ 4-1:0]  wstrb_i     ,
  input  logic           wlast_i     ,
  input  logic           wvalid_i    ,
  output logic           wready_o    ,
  // Write response
  output logic [IW-1:0]  bid_o       ,
  output logic [ 2-1:0]  bresp_o     ,
  output logic           bvalid_o    ,
  input  logic           bready_i    ,
  // Read address
  input  logic [IW-1:0]  arid_i      ,
  input  logic [32-1:0]  araddr_i    ,
  input  logic [ 4-1:0]  arlen_i     ,
  input  logic           arvalid_i   ,
  output logic           arready_o   ,
  // Read data
  output logic [IW-1:0]  rid_o       ,
  output logic [32-1:0]  rdata_o     ,
  output logic [ 2-1:0]  rresp_o     ,
  output logic           rlast_o     ,
  output logic           rvalid_o    ,
  input  logic           rready_i    ,
  // System bus master
  output logic [32-1:0]  sys_addr_o  ,
  output logic [32-1:0]  sys_wdata_o ,
  output logic [ 4-1:0]  sys_sel_o   ,
  output logic           sys_wen_o   ,
  output logic           sys_ren_o   ,
  input  logic [32-1:0]  sys_rdata_i ,
  input  logic           sys_ack_i   ,
  input  logic           sys_err_i
);

localparam int TW = $clog2(SYS_TIMEOUT + 1);
localparam logic [TW-1:0] TMO_LAST = TW'(SYS_TIMEOUT - 1);

// FSM encoding
localparam logic [2-1:0] ST_IDLE = 2'd0;
localparam logic [2-1:0] ST_BUS  = 2'd1;
localparam logic [2-1:0] ST_RESP = 2'd2;

logic [ 2-1:0] state_q;
logic [TW-1:0] tmo_cnt;
logic          tmo_hit;
logic          answer;    // Bus answer or timeout
logic          wr_burst;
logic          rd_burst;

// Captured transaction
logic [IW-1:0] id_q;
logic [32-1:0] addr_q;
logic [32-1:0] wdata_q;
logic [ 4-1:0] sel_q;
logic          wr_q;      // 1 for write, 0 for read
logic [ 2-1:0] resp_q;
logic [32-1:0] rdata_q;

assign wr_burst = (awlen_i != 4'd0) || !wlast_i;  // More than one beat
assign rd_burst = (arlen_i != 4'd0);
assign tmo_hit  = (tmo_cnt == TMO_LAST);
assign answer   = sys_ack_i || sys_err_i || tmo_hit;

//////////////////////////////////////////////////////////////////////
// Control FSM

always_ff @(posedge clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    state_q   <= ST_IDLE;
    awready_o <= 1'b0;
    wready_o  <= 1'b0;
    arready_o <= 1'b0;
    sys_wen_o <= 1'b0;
    sys_ren_o <= 1'b0;
    bvalid_o  <= 1'b0;
    rvalid_o  <= 1'b0;
    rlast_o   <= 1'b0;
    tmo_cnt   <= '0;
  end else begin
    case (state_q)
      ST_IDLE: begin
        tmo_cnt <= '0;
        if (awready_o) begin            // Write handshake on this edge
          awready_o <= 1'b0;
          wready_o  <= 1'b0;
          if (wr_burst) begin
            bvalid_o <= 1'b1;            // Reject without bus access
            state_q  <= ST_RESP;
          end else begin
            sys_wen_o <= 1'b1;
            state_q   <= ST_BUS;
          end
        end else if (arready_o) begin   // Read handshake on this edge
          arready_o <= 1'b0;
          if (rd_burst) begin
            rvalid_o <= 1'b1;
            rlast_o  <= 1'b1;
            state_q  <= ST_RESP;
          end else begin
            sys_ren_o <= 1'b1;
            state_q   <= ST_BUS;
          end
        end else if (awvalid_i && wvalid_i) begin
          awready_o <= 1'b1;             // Write has priority
          wready_o  <= 1'b1;
        end else if (arvalid_i) begin
          arready_o <= 1'b1;
        end
      end
      ST_BUS: begin
        sys_wen_o <= 1'b0;               // Single cycle strobe
        sys_ren_o <= 1'b0;
        tmo_cnt   <= tmo_cnt + 1'b1;
        if (answer) begin
          if (wr_q) begin
            bvalid_o <= 1'b1;
          end else begin
            rvalid_o <= 1'b1;
            rlast_o  <= 1'b1;
          end
          state_q <= ST_RESP;
        end
      end
      ST_RESP: begin
        // Hold until the master takes it
        if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
          bvalid_o <= 1'b0;
          rvalid_o <= 1'b0;
          rlast_o  <= 1'b0;
          state_q  <= ST_IDLE;
        end
      end
      default: state_q <= ST_IDLE;
    endcase
  end
end

//////////////////////////////////////////////////////////////////////
// Transaction capture and response

always_ff @(posedge clk_i) begin
  if ((state_q == ST_IDLE) && awready_o) begin
    id_q    <= awid_i;
    addr_q  <= awaddr_i;
    wdata_q <= wdata_i;
    sel_q   <= wstrb_i;
    wr_q    <= 1'b1;
    resp_q  <= RESP_SLVERR;           // Kept only for a burst
    rdata_q <= '0;
  end else if ((state_q == ST_IDLE) && arready_o) begin
    id_q    <= arid_i;
    addr_q  <= araddr_i;
    wdata_q <= '0;
    sel_q   <= 4'hF;                  // Full word read
    wr_q    <= 1'b0;
    resp_q  <= RESP_SLVERR;
    rdata_q <= '0;
  end else if ((state_q == ST_BUS) && answer) begin
    if (sys_ack_i && !sys_err_i) begin
      resp_q  <= RESP_OKAY;
      rdata_q <= sys_rdata_i;
    end else begin
      resp_q  <= RESP_SLVERR;         // Error or timeout
      rdata_q <= '0;
    end
  end
end

// Bus and response outputs from the captured registers
assign sys_addr_o  = addr_q;
assign sys_wdata_o = wdata_q;
assign sys_sel_o   = sel_q;

assign bid_o   = id_q;   // ID echo
assign bresp_o = resp_q;
assign rid_o   = id_q;
assign rresp_o = resp_q;
assign rdata_o = rdata_q;

endmodule

/* source/gpio_regs.sv */
/*
 * GPIO register slave
 * Output and direction registers, synchronized input readback
 */

module gpio_regs import ps_bus_pkg::*; #(
  parameter int GPIO_W = 24  // Number of GPIO lines
)(
  input  logic               clk_i    ,
  input  logic               arst_n_i ,
  // System bus slave, full word access, sel has no effect
  input  logic [    32-1:0]  addr_i   ,
  input  logic [    32-1:0]  wdata_i  ,
  input  logic [     4-1:0]  sel_i    ,
  input  logic               wen_i    ,
  input  logic               ren_i    ,
  output logic [    32-1:0]  rdata_o  ,
  output logic               ack_o    ,
  // GPIO pins
  input  logic [GPIO_W-1:0]  gpio_i   ,
  output logic [GPIO_W-1:0]  gpio_o   ,
  output logic [GPIO_W-1:0]  gpio_t_o   // 1 means input
);

logic [ OFS_W-1:0] offs;
logic [GPIO_W-1:0] in_meta;
logic [GPIO_W-1:0] in_sync;

assign offs = addr_i[OFS_W-1:0];

always_ff @(posedge clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    ack_o    <= 1'b0;
    gpio_o   <= '0;
    gpio_t_o <= '0;
    in_meta  <= '0;
    in_sync  <= '0;
  end else begin
    ack_o   <= wen_i || ren_i;
    in_meta <= gpio_i;   // Two flop synchronizer
    in_sync <= in_meta;
    if (wen_i && (offs == GPIO_OFS_OUT)) gpio_o   <= wdata_i[GPIO_W-1:0];
    if (wen_i && (offs == GPIO_OFS_DIR)) gpio_t_o <= wdata_i[GPIO_W-1:0];
  end
end

// Read data, zero extended
always_ff @(posedge clk_i) begin
  if (ren_i) begin
    rdata_o <= '0;
    case (offs)
      GPIO_OFS_OUT: rdata_o[GPIO_W-1:0] <= gpio_o;
      GPIO_OFS_DIR: rdata_o[GPIO_W-1:0] <= gpio_t_o;
      GPIO_OFS_IN:  rdata_o[GPIO_W-1:0] <= in_sync;
      default:      ;                    // Unknown offset reads zero
    endcase
  end
end

endmodule

/* source/hk_regs.sv */
/*
 * Housekeeping register slave
 * ID word, LED register and byte addressable scratch word
 */

module hk_regs import ps_bus_pkg::*; #(
  parameter logic [32-1:0] HK_ID = 32'h5250_0001  // Read-only ID word
)(
  input  logic           clk_i    ,
  input  logic           arst_n_i ,
  // System bus slave
  input  logic [32-1:0]  addr_i   ,
  input  logic [32-1:0]  wdata_i  ,
  input  logic [ 4-1:0]  sel_i    ,
  input  logic           wen_i    ,
  input  logic           ren_i    ,
  output logic [32-1:0]  rdata_o  ,
  output logic           ack_o    ,
  // LEDs
  output logic [ 8-1:0]  led_o
);

logic [OFS_W-1:0] offs;
logic [   32-1:0] scratch_q;

assign offs = addr_i[OFS_W-1:0];

//////////////////////////////////////////////////////////////////////
// Ack and LED register

always_ff @(posedge clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    ack_o <= 1'b0;
    led_o <= '0;
  end else begin
    ack_o <= wen_i || ren_i;  // Every offset answers
    if (wen_i && (offs == HK_OFS_LED) && sel_i[0]) begin
      led_o <= wdata_i[7:0];  // Byte lane 0 only
    end
  end
end

//////////////////////////////////////////////////////////////////////
// Scratch word

always_ff @(posedge clk_i) begin
  if (wen_i && (offs == HK_OFS_SCRATCH)) begin
    for (int b = 0; b < 4; b++) begin
      if (sel_i[b]) scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];  // Per lane
    end
  end
end

//////////////////////////////////////////////////////////////////////
// Read data

always_ff @(posedge clk_i) begin
  if (ren_i) begin
    case (offs)
      HK_OFS_ID:      rdata_o <= HK_ID;
      HK_OFS_LED:     rdata_o <= {24'h0, led_o};
      HK_OFS_SCRATCH: rdata_o <= scratch_q;
      default:        rdata_o <= '0;  // Unknown offset
    endcase
  end
end

endmodule

/* source/ps_bus_pkg.sv */
/*
 * Shared definitions of the PS system bus
 * AXI response codes, region select field and register offsets
 */

package ps_bus_pkg;

  // AXI response codes
  localparam logic [2-1:0] RESP_OKAY   = 2'd0;
  localparam logic [2-1:0] RESP_SLVERR = 2'd2;

  // Region select field in the byte address
  localparam int REGION_MSB = 22;
  localparam int REGION_LSB = 20;

  localparam logic [3-1:0] REGION_HK   = 3'd0;  // Housekeeping
  localparam logic [3-1:0] REGION_GPIO = 3'd1;  // GPIO, other codes unmapped

  // Offsets are compared on the bits below the region field
  localparam int OFS_W = 20;

  localparam logic [OFS_W-1:0] HK_OFS_ID      = 20'h0_0000;
  localparam logic [OFS_W-1:0] HK_OFS_LED     = 20'h0_0004;
  localparam logic [OFS_W-1:0] HK_OFS_SCRATCH = 20'h0_0008;

  localparam logic [OFS_W-1:0] GPIO_OFS_OUT = 20'h0_0000;
  localparam logic [OFS_W-1:0] GPIO_OFS_DIR = 20'h0_0004;
  localparam logic [OFS_W-1:0] GPIO_OFS_IN  = 20'h0_0008;

endpackage

/* source/ps_bus_top.sv */
/*
 * PL side of the processor wrapper
 * AXI GP slave, system bus decoder and two register slaves
 */

module ps_bus_top #(
  parameter int            IW          = 12,
  parameter int            SYS_TIMEOUT = 16,
  parameter int            GPIO_W      = 24,
  parameter logic [32-1:0] HK_ID       = 32'h5250_0001
)(
  input  logic               clk_i     ,
  input  logic               arst_n_i  ,
  // AXI3 GP port
  input  logic [    IW-1:0]  awid_i    ,
  input  logic [    32-1:0]  awaddr_i  ,
  input  logic [     4-1:0]  awlen_i   ,
  input  logic               awvalid_i ,
  output logic               awready_o ,
  input  logic [    32-1:0]  wdata_i   ,
  input  logic [     4-1:0]  wstrb_i   ,
  input  logic               wlast_i   ,
  input  logic               wvalid_i  ,
  output logic               wready_o  ,
  output logic [    IW-1:0]  bid_o     ,
  output logic [     2-1:0]  bresp_o   ,
  output logic               bvalid_o  ,
  input  logic               bready_i  ,
  input  logic [    IW-1:0]  arid_i    ,
  input  logic [    32-1:0]  araddr_i  ,
  input  logic [     4-1:0]  arlen_i   ,
  input  logic               arvalid_i ,
  output logic               arready_o ,
  output logic [    IW-1:0]  rid_o     ,
  output logic [    32-1:0]  rdata_o   ,
  output logic [     2-1:0]  rresp_o   ,
  output logic               rlast_o   ,
  output logic               rvalid_o  ,
  input  logic               rready_i  ,
  // Peripherals
  output logic [     8-1:0]  led_o     ,
  input  logic [GPIO_W-1:0]  gpio_i    ,
  output logic [GPIO_W-1:0]  gpio_o    ,
  output logic [GPIO_W-1:0]  gpio_t_o
);

//////////////////////////////////////////////////////////////////////
// System bus wires

logic [32-1:0] sys_addr,  sys_wdata, sys_rdata;
logic [ 4-1:0] sys_sel;
logic          sys_wen, sys_ren, sys_ack, sys_err;

logic [32-1:0] hk_addr, hk_wdata, hk_rdata;
logic [ 4-1:0] hk_sel;
logic          hk_wen, hk_ren, hk_ack;

logic [32-1:0] gpio_addr, gpio_wdata, gpio_rdata;
logic [ 4-1:0] gpio_sel;
logic          gpio_wen, gpio_ren, gpio_ack;

//////////////////////////////////////////////////////////////////////
// AXI slave, bus master side

axi_gp_slave #(
  .IW          (IW         ),
  .SYS_TIMEOUT (SYS_TIMEOUT)
) axi_gp_slave_inst (
  .clk_i       (clk_i     ),
  .arst_n_i    (arst_n_i  ),
  .awid_i      (awid_i    ),
  .awaddr_i    (awaddr_i  ),
  .awlen_i     (awlen_i   ),
  .awvalid_i   (awvalid_i ),
  .awready_o   (awready_o ),
  .wdata_i     (wdata_i   ),
  .wstrb_i     (wstrb_i   ),
  .wlast_i     (wlast_i   ),
  .wvalid_i    (wvalid_i  ),
  .wready_o    (wready_o  ),
  .bid_o       (bid_o     ),
  .bresp_o     (bresp_o   ),
  .bvalid_o    (bvalid_o  ),
  .bready_i    (bready_i  ),
  .arid_i      (arid_i    ),
  .araddr_i    (araddr_i  ),
  .arlen_i     (arlen_i   ),
  .arvalid_i   (arvalid_i ),
  .arready_o   (arready_o ),
  .rid_o       (rid_o     ),
  .rdata_o     (rdata_o   ),
  .rresp_o     (rresp_o   ),
  .rlast_o     (rlast_o   ),
  .rvalid_o    (rvalid_o  ),
  .rready_i    (rready_i  ),
  .sys_addr_o  (sys_addr  ),
  .sys_wdata_o (sys_wdata ),
  .sys_sel_o   (sys_sel   ),
  .sys_wen_o   (sys_wen   ),
  .sys_ren_o   (sys_ren   ),
  .sys_rdata_i (sys_rdata ),
  .sys_ack_i   (sys_ack   ),
  .sys_err_i   (sys_err   )
);

//////////////////////////////////////////////////////////////////////
// Region decoder

sys_bus_decoder sys_bus_decoder_inst (
  .clk_i        (clk_i      ),
  .arst_n_i     (arst_n_i   ),
  .sys_addr_i   (sys_addr   ),
  .sys_wdata_i  (sys_wdata  ),
  .sys_sel_i    (sys_sel    ),
  .sys_wen_i    (sys_wen    ),
  .sys_ren_i    (sys_ren    ),
  .sys_rdata_o  (sys_rdata  ),
  .sys_ack_o    (sys_ack    ),
  .sys_err_o    (sys_err    ),
  .hk_addr_o    (hk_addr    ),
  .hk_wdata_o   (hk_wdata   ),
  .hk_sel_o     (hk_sel     ),
  .hk_wen_o     (hk_wen     ),
  .hk_ren_o     (hk_ren     ),
  .hk_rdata_i   (hk_rdata   ),
  .hk_ack_i     (hk_ack     ),
  .gpio_addr_o  (gpio_addr  ),
  .gpio_wdata_o (gpio_wdata ),
  .gpio_sel_o   (gpio_sel   ),
  .gpio_wen_o   (gpio_wen   ),
  .gpio_ren_o   (gpio_ren   ),
  .gpio_rdata_i (gpio_rdata ),
  .gpio_ack_i   (gpio_ack   )
);

//////////////////////////////////////////////////////////////////////
// Register slaves

hk_regs #(
  .HK_ID (HK_ID)
) hk_regs_inst (
  .clk_i    (clk_i    ),
  .arst_n_i (arst_n_i ),
  .addr_i   (hk_addr  ),
  .wdata_i  (hk_wdata ),
  .sel_i    (hk_sel   ),
  .wen_i    (hk_wen   ),
  .ren_i    (hk_ren   ),
  .rdata_o  (hk_rdata ),
  .ack_o    (hk_ack   ),
  .led_o    (led_o    )
);

gpio_regs #(
  .GPIO_W (GPIO_W)
) gpio_regs_inst (
  .clk_i    (clk_i      ),
  .arst_n_i (arst_n_i   ),
  .addr_i   (gpio_addr  ),
  .wdata_i  (gpio_wdata ),
  .sel_i    (gpio_sel   ),
  .wen_i    (gpio_wen   ),
  .ren_i    (gpio_ren   ),
  .rdata_o  (gpio_rdata ),
  .ack_o    (gpio_ack   ),
  .gpio_i   (gpio_i     ),
  .gpio_o   (gpio_o     ),
  .gpio_t_o (gpio_t_o   )
);

endmodule

/* source/sys_bus_decoder.sv */
/*
 * System bus region decoder
 * Routes strobes to one slave and returns its read data and ack
 * Unmapped regions answer with an error pulse
 */

module sys_bus_decoder import ps_bus_pkg::*; (
  input  logic           clk_i         ,
  input  logic           arst_n_i      ,
  // From the bus master
  input  logic [32-1:0]  sys_addr_i    ,
  input  logic [32-1:0]  sys_wdata_i   ,
  input  logic [ 4-1:0]  sys_sel_i     ,
  input  logic           sys_wen_i     ,
  input  logic           sys_ren_i     ,
  output logic [32-1:0]  sys_rdata_o   ,
  output logic           sys_ack_o     ,
  output logic           sys_err_o     ,
  // Housekeeping slave
  output logic [32-1:0]  hk_addr_o     ,
  output logic [32-1:0]  hk_wdata_o    ,
  output logic [ 4-1:0]  hk_sel_o      ,
  output logic           hk_wen_o      ,
  output logic           hk_ren_o      ,
  input  logic [32-1:0]  hk_rdata_i    ,
  input  logic           hk_ack_i      ,
  // GPIO slave
  output logic [32-1:0]  gpio_addr_o   ,
  output logic [32-1:0]  gpio_wdata_o  ,
  output logic [ 4-1:0]  gpio_sel_o    ,
  output logic           gpio_wen_o    ,
  output logic           gpio_ren_o    ,
  input  logic [32-1:0]  gpio_rdata_i  ,
  input  logic           gpio_ack_i
);

logic [3-1:0] region;
logic         hit_hk;
logic         hit_gpio;
logic         err_q;

assign region   = sys_addr_i[REGION_MSB:REGION_LSB];
assign hit_hk   = (region == REGION_HK);
assign hit_gpio = (region == REGION_GPIO);

// Address, data and sel go to both, strobes only to the selected one
assign hk_addr_o    = sys_addr_i;
assign hk_wdata_o   = sys_wdata_i;
assign hk_sel_o     = sys_sel_i;
assign hk_wen_o     = sys_wen_i && hit_hk;
assign hk_ren_o     = sys_ren_i && hit_hk;

assign gpio_addr_o  = sys_addr_i;
assign gpio_wdata_o = sys_wdata_i;
assign gpio_sel_o   = sys_sel_i;
assign gpio_wen_o   = sys_wen_i && hit_gpio;
assign gpio_ren_o   = sys_ren_i && hit_gpio;

// Answer mux, address is held by the master until the answer
always_comb begin
  sys_rdata_o = '0;
  sys_ack_o   = 1'b0;
  if (hit_hk) begin
    sys_rdata_o = hk_rdata_i;
    sys_ack_o   = hk_ack_i;
  end else if (hit_gpio) begin
    sys_rdata_o = gpio_rdata_i;
    sys_ack_o   = gpio_ack_i;
  end
end

// Error pulse one cycle after a strobe to an unmapped region
always_ff @(posedge clk_i or negedge arst_n_i) begin
  if (!arst_n_i) err_q <= 1'b0;
  else           err_q <= (sys_wen_i || sys_ren_i) && !hit_hk && !hit_gpio;
end

assign sys_err_o = err_q;

endmodule

/* testbench/ps_bus_asserts.sv */
/*
 * Protocol assertions for the AXI GP slave
 * Response hold, strobe width and strobe exclusion
 */

module ps_bus_asserts (
  input  logic  clk_i    ,
  input  logic  arst_n_i ,
  input  logic  bvalid_i ,
  input  logic  bready_i ,
  input  logic  rvalid_i ,
  input  logic  rready_i ,
  input  logic  wen_i    ,
  input  logic  ren_i
);

timeunit 1ns;
timeprecision 100ps;

//////////////////////////////////////////////////////////////////////
// AXI response channels

a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
  (bvalid_i && !bready_i) |=> bvalid_i)
  else $error("bvalid dropped before its handshake");

a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
  (rvalid_i && !rready_i) |=> rvalid_i)
  else $error("rvalid dropped before its handshake");

//////////////////////////////////////////////////////////////////////
// System bus strobes

a_wen_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
  wen_i |=> !wen_i)
  else $error("write strobe longer than one cycle");

a_ren_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
  ren_i |=> !ren_i)
  else $error("read strobe longer than one cycle");

a_wen_ren_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
  !(wen_i && ren_i))
  else $error("write and read strobe in the same cycle");

endmodule

/* testbench/ps_bus_stim.txt */
// op (0 wr, 1 rd, 2 wr late bready, 3 rd late rready) addr len data strb gpio_in
// exp_resp exp_data (for a write: led_o, gpio_o or gpio_t_o behind the address)
1 40000000 0 00000000 0 000000 0 52500001
0 40000000 0 DEADBEEF F 000000 0 00000000
3 40000000 0 00000000 0 000000 0 52500001
0 40000008 0 11223344 F 000000 0 00000000
0 40000008 0 AABBCCDD 5 000000 0 00000000
1 40000008 0 00000000 0 000000 0 11BB33DD
2 40000008 0 55667788 A 000000 0 00000000
3 40000008 0 00000000 0 000000 0 55BB77DD
0 40000004 0 000000A5 1 000000 0 000000A5
2 40000004 0 0000005A 2 000000 0 000000A5
1 40000004 0 00000000 0 000000 0 000000A5
0 40100000 0 00C3A55A F 000000 0 00C3A55A
2 40100004 0 00F0F00F F 000000 0 00F0F00F
1 40100000 0 00000000 0 000000 0 00C3A55A
3 40100004 0 00000000 0 000000 0 00F0F00F
1 40100008 0 00000000 0 123456 0 00123456
3 40100008 0 00000000 0 ABCDEF 0 00ABCDEF
1 40300000 0 00000000 0 000000 2 00000000
0 40200004 0 12345678 F 000000 2 00000000
3 40000000 3 00000000 0 000000 2 00000000
2 40000008 1 CAFEF00D F 000000 2 00000000
1 40000008 0 00000000 0 000000 0 55BB77DD
1 40000000 0 00000000 0 000000 0 52500001

/* testbench/tb_ps_bus.sv */
/*
 * Testbench for the PS bus subsystem
 * Clock, reset, AXI3 master tasks, stimulus file reader, checks, timeout
 */

module tb_ps_bus
  import ps_bus_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int            IW          = 12;
localparam int            SYS_TIMEOUT = 16;
localparam int            GPIO_W      = 24;
localparam logic [32-1:0] HK_ID       = 32'h5250_0001;
localparam string         STIM_FILE   = "testbench/ps_bus_stim.txt";

logic              clk = 1'b0;
logic              arst_n;
logic [    IW-1:0] awid, arid, bid, rid;
logic [    32-1:0] awaddr, araddr, wdata, rdata;
logic [     4-1:0] awlen, arlen, wstrb;
logic              awvalid, awready, wlast, wvalid, wready;
logic [     2-1:0] bresp, rresp;
logic              bvalid, bready, arvalid, arready;
logic              rlast, rvalid, rready;
logic [     8-1:0] led;
logic [GPIO_W-1:0] gpio_in, gpio_out, gpio_dir;

// One entry per stimulus line, columns as in the file
logic [32-1:0] st_op[$];
logic [32-1:0] st_addr[$];
logic [32-1:0] st_len[$];
logic [32-1:0] st_data[$];
logic [32-1:0] st_strb[$];
logic [32-1:0] st_gin[$];
logic [32-1:0] st_resp[$];
logic [32-1:0] st_rdat[$];

integer seed         = 32'h7b3777b9;
int     cycle_cnt    = 0;
int     limit_cycles = 0;  // 0 until the file is read

always #2 clk = ~clk;  // 4 ns period

ps_bus_top #(
  .IW (IW), .SYS_TIMEOUT (SYS_TIMEOUT), .GPIO_W (GPIO_W), .HK_ID (HK_ID)
) ps_bus_top_inst (
  .clk_i (clk), .arst_n_i (arst_n),
  .awid_i (awid), .awaddr_i (awaddr), .awlen_i (awlen),
  .awvalid_i (awvalid), .awready_o (awready),
  .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast),
  .wvalid_i (wvalid), .wready_o (wready),
  .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
  .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen),
  .arvalid_i (arvalid), .arready_o (arready),
  .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rlast_o (rlast),
  .rvalid_o (rvalid), .rready_i (rready),
  .led_o (led), .gpio_i (gpio_in), .gpio_o (gpio_out), .gpio_t_o (gpio_dir)
);

bind axi_gp_slave ps_bus_asserts ps_bus_asserts_inst (
  .clk_i (clk_i), .arst_n_i (arst_n_i),
  .bvalid_i (bvalid_o), .bready_i (bready_i),
  .rvalid_i (rvalid_o), .rready_i (rready_i),
  .wen_i (sys_wen_o), .ren_i (sys_ren_o)
);

//////////////////////////////////////////////////////////////////////
// Failure reporting and checks

task automatic stop_with_failure(input string msg);
  $display("%s", msg);
  $display("TEST RESULT: FAIL");
  $fatal(1, "simulation stopped");
endtask

task automatic check_value(input logic [32-1:0] actual, input logic [32-1:0] expected,
                           input string what);
  if (actual !== expected) begin
    stop_with_failure($sformatf("Fail at %0t: %s is %08h, expected %08h",
                                $time, what, actual, expected));
  end
endtask

// Peripheral output behind a written register, if there is one
task automatic check_outputs(input logic [32-1:0] addr, input logic [32-1:0] expected,
                             input int line_no);
  logic [    3-1:0] region;
  logic [OFS_W-1:0] ofs;
  region = addr[REGION_MSB:REGION_LSB];
  ofs    = addr[OFS_W-1:0];
  if ((region == REGION_HK) && (ofs == HK_OFS_LED)) begin
    check_value(32'(led), expected, $sformatf("line %0d led_o", line_no));
  end else if ((region == REGION_GPIO) && (ofs == GPIO_OFS_OUT)) begin
    check_value(32'(gpio_out), expected, $sformatf("line %0d gpio_o", line_no));
  end else if ((region == REGION_GPIO) && (ofs == GPIO_OFS_DIR)) begin
    check_value(32'(gpio_dir), expected, $sformatf("line %0d gpio_t_o", line_no));
  end
endtask

// Cycle limit
always @(posedge clk) begin
  cycle_cnt = cycle_cnt + 1;
  if ((limit_cycles > 0) && (cycle_cnt > limit_cycles)) begin
    stop_with_failure("Timeout: the accesses did not complete within the cycle limit");
  end
end

//////////////////////////////////////////////////////////////////////
// AXI master, called and returning on a falling edge

task automatic axi_write(
  input  logic [IW-1:0] id,
  input  logic [32-1:0] addr,
  input  logic [ 4-1:0] len,
  input  logic [32-1:0] data,
  input  logic [ 4-1:0] strb,
  input  int            delay,
  output logic [IW-1:0] rsp_id,
  output logic [ 2-1:0] rsp
);
  awid    = id;
  awaddr  = addr;
  awlen   = len;
  wdata   = data;
  wstrb   = strb;
  wlast   = (len == 4'd0);  // One beat is all that is sent
  awvalid = 1'b1;
  wvalid  = 1'b1;
  bready  = (delay == 0);
  do begin
    @(negedge clk);
  end while (!awready);
  check_value(32'(wready), 32'd1, "wready with awready");
  @(negedge clk);           // Handshake done
  awvalid = 1'b0;
  wvalid  = 1'b0;
  while (!bvalid) @(negedge clk);
  repeat (delay) @(negedge clk);
  check_value(32'(bvalid), 32'd1, "bvalid held");
  rsp_id = bid;
  rsp    = bresp;
  bready = 1'b1;
  @(negedge clk);
endtask

task automatic axi_read(
  input  logic [IW-1:0] id,
  input  logic [32-1:0] addr,
  input  logic [ 4-1:0] len,
  input  int            delay,
  output logic [IW-1:0] rsp_id,
  output logic [ 2-1:0] rsp,
  output logic [32-1:0] data,
  output logic          last
);
  arid    = id;
  araddr  = addr;
  arlen   = len;
  arvalid = 1'b1;
  rready  = (delay == 0);
  do begin
    @(negedge clk);
  end while (!arready);
  @(negedge clk);
  arvalid = 1'b0;
  while (!rvalid) @(negedge clk);
  repeat (delay) @(negedge clk);
  check_value(32'(rvalid), 32'd1, "rvalid held");
  rsp_id = rid;             // Sampled just before the handshake
  rsp    = rresp;
  data   = rdata;
  last   = rlast;
  rready = 1'b1;
  @(negedge clk);
endtask

//////////////////////////////////////////////////////////////////////
// Main sequence

initial begin
  int            fd;
  int            n_fields;
  int            delay;
  string         line;
  logic [32-1:0] f_op, f_addr, f_len, f_data, f_strb, f_gin, f_resp, f_rdat;
  logic [IW-1:0] id;
  logic [IW-1:0] rsp_id;
  logic [ 2-1:0] rsp;
  logic [32-1:0] rd_data;
  logic          rd_last;

  arst_n  = 1'b0;
  awid    = '0;
  awaddr  = '0;
  awlen   = '0;
  awvalid = 1'b0;
  wdata   = '0;
  wstrb   = '0;
  wlast   = 1'b0;
  wvalid  = 1'b0;
  bready  = 1'b1;
  arid    = '0;
  araddr  = '0;
  arlen   = '0;
  arvalid = 1'b0;
  rready  = 1'b1;
  gpio_in = '0;

  fd = $fopen(STIM_FILE, "r");
  if (fd == 0) begin
    stop_with_failure({"Cannot open the stimulus file ", STIM_FILE});
  end
  while (!$feof(fd)) begin
    line = "";
    void'($fgets(line, fd));
    n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                       f_op, f_addr, f_len, f_data, f_strb, f_gin, f_resp, f_rdat);
    if (n_fields == 8) begin  // Comment and blank lines skipped
      st_op.push_back(f_op);
      st_addr.push_back(f_addr);
      st_len.push_back(f_len);
      st_data.push_back(f_data);
      st_strb.push_back(f_strb);
      st_gin.push_back(f_gin);
      st_resp.push_back(f_resp);
      st_rdat.push_back(f_rdat);
    end
  end
  $fclose(fd);
  if (st_op.size() == 0) begin
    stop_with_failure("The stimulus file holds no access lines");
  end
  limit_cycles = st_op.size() * (SYS_TIMEOUT + 20);

  repeat (4) @(negedge clk);
  arst_n = 1'b1;
  @(negedge clk);
  check_value(32'(bvalid), 32'd0, "bvalid_o after reset");
  check_value(32'(rvalid), 32'd0, "rvalid_o after reset");
  check_value(32'(led), 32'd0, "led_o after reset");
  check_value(32'(gpio_out), 32'd0, "gpio_o after reset");
  check_value(32'(gpio_dir), 32'd0, "gpio_t_o after reset");

  for (int i = 0; i < st_op.size(); i++) begin
    gpio_in = st_gin[i][GPIO_W-1:0];
    id      = IW'(i + 1);
    if (st_op[i][1]) delay = 1 + ($random(seed) & 3);  // Late ready
    else             delay = 0;
    if (st_op[i][0]) begin
      axi_read(id, st_addr[i], st_len[i][3:0], delay, rsp_id, rsp, rd_data, rd_last);
      check_value(32'(rsp_id), 32'(id), $sformatf("line %0d rid", i));
      check_value(32'(rsp), st_resp[i], $sformatf("line %0d rresp", i));
      check_value(rd_data, st_rdat[i], $sformatf("line %0d rdata", i));
      check_value(32'(rd_last), 32'd1, $sformatf("line %0d rlast", i));
    end else begin
      axi_write(id, st_addr[i], st_len[i][3:0], st_data[i], st_strb[i][3:0], delay,
                rsp_id, rsp);
      check_value(32'(rsp_id), 32'(id), $sformatf("line %0d bid", i));
      check_value(32'(rsp), st_resp[i], $sformatf("line %0d bresp", i));
      check_outputs(st_addr[i], st_rdat[i], i);
    end
  end

  $display("TEST RESULT: PASS");
  $finish;
end

endmodule
